/* qeci_link_test.f */
logic/qeci_link_pkg.sv
logic/test_cfg_if.sv
logic/link_reset_seq.sv
logic/pattern_gen.sv
logic/pattern_check.sv
logic/lane_model.sv
logic/test_ctrl_regs.sv
logic/qeci_link_test_top.sv
testbench/tb_qeci_link_test.sv

/* testbench/tb_qeci_link_test.sv */
/* Directed testbench for the link self-test harness, driven only over the host port.
   Outputs are sampled on the falling edge. The run stops at TIMEOUT_CYCLES. */

module tb_qeci_link_test;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES   = 16;
   localparam int ALIGN_WORDS    = 8;
   localparam int LANE_LATENCY   = 4;
   // Five tests of at most about 500 cycles each plus margin
   localparam int TIMEOUT_CYCLES = 5 * 500 + 500;

   logic        FCLK;
   logic        ARSTn;
   logic        reg_req;
   logic        reg_we;
   logic [2:0]  reg_addr;
   logic [31:0] reg_wdata;
   logic        reg_ack;
   logic [31:0] reg_rdata;
   logic [1:0]  led;
   logic [31:0] lfsr_q    = 32'd78292;
   int          cycle_cnt = 0;
   int          errors    = 0;
   int          checks    = 0;
   int          tests_run = 0;

   qeci_link_test_top #(
      .RESET_CYCLES(RESET_CYCLES),
      .ALIGN_WORDS (ALIGN_WORDS),
      .LANE_LATENCY(LANE_LATENCY)
   ) dut (
      .FCLK     (FCLK),
      .ARSTn    (ARSTn),
      .reg_req  (reg_req),
      .reg_we   (reg_we),
      .reg_addr (reg_addr),
      .reg_wdata(reg_wdata),
      .reg_ack  (reg_ack),
      .reg_rdata(reg_rdata),
      .led      (led)
   );

   initial FCLK = 1'b0;
   always #20 FCLK = ~FCLK;

   always @(posedge FCLK) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt == TIMEOUT_CYCLES) begin
         $display("Run stopped at %0d ns: no result after %0d cycles", $time, cycle_cnt);
         $display("Some tests failed");
         $finish;
      end
   end

   // 32-bit Fibonacci LFSR with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   task automatic take_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val    = {val[30:0], lfsr_q[31]};
         lfsr_q = lfsr_step(lfsr_q);
      end
   endtask

   task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got 0x%08h expected 0x%08h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_status(input string name, input qeci_link_pkg::link_status_e got,
                               input qeci_link_pkg::link_status_e exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got %s expected %s", $time, name, got.name(), exp.name());
         errors++;
      end
   endtask

   task automatic check_ecode(input string name, input qeci_link_pkg::link_ecode_e got,
                              input qeci_link_pkg::link_ecode_e exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got %s expected %s", $time, name, got.name(), exp.name());
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic got, input logic exp);
      checks++;
      if (got !== exp) begin
         $display("MISMATCH at %0d ns: %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_failure(input string msg);
      checks++;
      errors++;
      $display("ERROR at %0d ns: %s", $time, msg);
   endtask

   task automatic report_test(input string name, input int errors_before);
      tests_run++;
      if (errors == errors_before) begin
         $display("%s: ok", name);
      end else begin
         $display("%s: %0d errors", name, errors - errors_before);
      end
   endtask

   // Four-phase req/ack that returns once ack is low again
   task automatic host_access(input logic we, input qeci_link_pkg::reg_addr_e addr,
                              input logic [31:0] wdata, output logic [31:0] rdata);
      @(posedge FCLK);
      reg_req   <= 1'b1;
      reg_we    <= we;
      reg_addr  <= addr;
      reg_wdata <= wdata;
      @(negedge FCLK);
      while (!reg_ack) @(negedge FCLK);
      rdata = reg_rdata;
      @(posedge FCLK);
      reg_req <= 1'b0;
      @(negedge FCLK);
      while (reg_ack) @(negedge FCLK);
   endtask

   task automatic reg_write(input qeci_link_pkg::reg_addr_e addr, input logic [31:0] wdata);
      logic [31:0] unused;
      host_access(1'b1, addr, wdata, unused);
   endtask

   task automatic reg_read(input qeci_link_pkg::reg_addr_e addr, output logic [31:0] rdata);
      host_access(1'b0, addr, 32'd0, rdata);
   endtask

   // LINK_STAT holds status in 3:0, ecode in 7:4 and the error flag in bit 8
   task automatic read_link_stat(output qeci_link_pkg::link_status_e st,
                                 output qeci_link_pkg::link_ecode_e ec, output logic flag);
      logic [31:0] rd;
      reg_read(qeci_link_pkg::LINK_STAT, rd);
      st   = qeci_link_pkg::link_status_e'(rd[3:0]);
      ec   = qeci_link_pkg::link_ecode_e'(rd[7:4]);
      flag = rd[8];
   endtask

   task automatic wait_link_up;
      qeci_link_pkg::link_status_e st;
      qeci_link_pkg::link_ecode_e  ec;
      logic                        flag;
      int                          polls;
      polls = 0;
      st    = qeci_link_pkg::RESET;
      while (st != qeci_link_pkg::LINK_UP && polls < 60) begin
         read_link_stat(st, ec, flag);
         polls++;
      end
      if (st != qeci_link_pkg::LINK_UP) begin
         report_failure($sformatf("link not up after %0d polls of LINK_STAT", polls));
      end
   endtask

   // Soft reset turns the generator off and the link retrains
   task automatic soft_reset_link;
      int n;
      reg_write(qeci_link_pkg::CONTROL, 32'h2);
      n = 0;
      while (led[0] && n < 10) begin
         @(negedge FCLK);
         n++;
      end
      if (led[0]) begin
         report_failure("link stayed up through a soft reset");
      end
      wait_link_up();
   endtask

   task automatic bring_up;
      qeci_link_pkg::link_status_e st;
      qeci_link_pkg::link_ecode_e  ec;
      logic                        flag;
      logic [31:0]                 rd;
      int                          e0;
      e0 = errors;
      reg_read(qeci_link_pkg::CONTROL, rd);
      check_word("CONTROL", rd, 32'd0);
      wait_link_up();
      read_link_stat(st, ec, flag);
      check_status("LINK_STAT.status", st, qeci_link_pkg::LINK_UP);
      check_ecode("LINK_STAT.ecode", ec, qeci_link_pkg::NONE);
      @(negedge FCLK);
      check_bit("led[0]", led[0], 1'b1);
      check_bit("led[1]", led[1], 1'b1);
      report_test("bring-up", e0);
   endtask

   task automatic register_access;
      logic [31:0] lo;
      logic [31:0] hi;
      logic [31:0] rd;
      int          e0;
      e0 = errors;
      take_bits(32, lo);
      take_bits(32, hi);
      reg_write(qeci_link_pkg::START_LO, lo);
      reg_write(qeci_link_pkg::START_HI, hi);
      reg_read(qeci_link_pkg::START_LO, rd);
      check_word("START_LO", rd, lo);
      reg_read(qeci_link_pkg::START_HI, rd);
      check_word("START_HI", rd, hi);
      // All three pulse bits set while gen_enable stays 0
      reg_write(qeci_link_pkg::CONTROL, 32'hE);
      reg_read(qeci_link_pkg::CONTROL, rd);
      check_word("CONTROL", rd, 32'd0);
      report_test("register access", e0);
   endtask

   task automatic clean_traffic;
      qeci_link_pkg::link_status_e st;
      qeci_link_pkg::link_ecode_e  ec;
      logic                        flag;
      logic [31:0]                 lo;
      logic [31:0]                 hi;
      logic [31:0]                 w1;
      logic [31:0]                 rd;
      int                          e0;
      e0 = errors;
      take_bits(32, lo);
      take_bits(32, hi);
      reg_write(qeci_link_pkg::START_LO, lo);
      reg_write(qeci_link_pkg::START_HI, hi);
      soft_reset_link();
      reg_write(qeci_link_pkg::CONTROL, 32'h1);
      repeat (100) @(posedge FCLK);
      reg_write(qeci_link_pkg::CONTROL, 32'h0);
      repeat (LANE_LATENCY + 2) @(posedge FCLK);
      reg_read(qeci_link_pkg::WORDS_LO, w1);
      if (w1 == 32'd0) begin
         report_failure("WORDS_LO still zero after 100 cycles of traffic");
      end
      reg_read(qeci_link_pkg::WORDS_LO, rd);
      check_word("WORDS_LO", rd, w1);
      reg_read(qeci_link_pkg::ERR_COUNT, rd);
      check_word("ERR_COUNT", rd, 32'd0);
      read_link_stat(st, ec, flag);
      check_bit("LINK_STAT.error_flag", flag, 1'b0);
      report_test("clean traffic", e0);
   endtask

   task automatic data_fault;
      qeci_link_pkg::link_status_e st;
      qeci_link_pkg::link_ecode_e  ec;
      logic                        flag;
      logic [31:0]                 rd;
      int                          e0;
      e0 = errors;
      reg_write(qeci_link_pkg::CONTROL, 32'h1);
      repeat (10) @(posedge FCLK);
      // Generator stays on while one word gets payload bit 0 flipped
      reg_write(qeci_link_pkg::CONTROL, 32'h5);
      repeat (LANE_LATENCY + 10) @(posedge FCLK);
      reg_read(qeci_link_pkg::ERR_COUNT, rd);
      check_word("ERR_COUNT", rd, 32'd1);
      read_link_stat(st, ec, flag);
      check_bit("LINK_STAT.error_flag", flag, 1'b1);
      check_ecode("LINK_STAT.ecode", ec, qeci_link_pkg::NONE);
      @(negedge FCLK);
      check_bit("led[1]", led[1], 1'b1);
      report_test("data fault", e0);
   endtask

   task automatic header_fault;
      qeci_link_pkg::link_status_e st;
      qeci_link_pkg::link_ecode_e  ec;
      logic                        flag;
      logic [31:0]                 e1;
      logic [31:0]                 rd;
      int                          e0;
      e0 = errors;
      reg_write(qeci_link_pkg::CONTROL, 32'h9);
      repeat (LANE_LATENCY + 10) @(posedge FCLK);
      read_link_stat(st, ec, flag);
      check_ecode("LINK_STAT.ecode", ec, qeci_link_pkg::HEADER);
      @(negedge FCLK);
      check_bit("led[1]", led[1], 1'b0);
      // The dropped word puts the checker one count behind
      reg_read(qeci_link_pkg::ERR_COUNT, e1);
      repeat (20) @(posedge FCLK);
      reg_read(qeci_link_pkg::ERR_COUNT, rd);
      if (rd <= e1) begin
         report_failure($sformatf("ERR_COUNT stuck at %0d after the dropped word", rd));
      end
      soft_reset_link();
      read_link_stat(st, ec, flag);
      check_status("LINK_STAT.status", st, qeci_link_pkg::LINK_UP);
      check_ecode("LINK_STAT.ecode", ec, qeci_link_pkg::NONE);
      reg_read(qeci_link_pkg::ERR_COUNT, rd);
      check_word("ERR_COUNT", rd, 32'd0);
      @(negedge FCLK);
      check_bit("led[0]", led[0], 1'b1);
      check_bit("led[1]", led[1], 1'b1);
      report_test("header fault and recovery", e0);
   endtask

   initial begin
      ARSTn     = 1'b0;
      reg_req   = 1'b0;
      reg_we    = 1'b0;
      reg_addr  = 3'd0;
      reg_wdata = 32'd0;
      repeat (2) @(posedge FCLK);
      ARSTn <= 1'b1;
      bring_up();
      register_access();
      clean_traffic();
      data_fault();
      header_fault();
      $display("Tests run %0d, checks %0d, errors %0d", tests_run, checks, errors);
      if (errors == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

/* logic/qeci_link_test_top.sv */
/* Link self-test harness top level. Single clock domain on FCLK.
   led[0] shows link up, led[1] shows no lane error. */

module qeci_link_test_top #(
   parameter int RESET_CYCLES = 16,
   parameter int ALIGN_WORDS  = 8,
   parameter int LANE_LATENCY = 4
) (
   input  logic        FCLK,
   input  logic        ARSTn,
   input  logic        reg_req,
   input  logic        reg_we,
   input  logic [2:0]  reg_addr,
   input  logic [31:0] reg_wdata,
   output logic        reg_ack,
   output logic [31:0] reg_rdata,
   output logic [1:0]  led
);

   logic                        link_rst_n;
   logic                        soft_reset;
   logic [63:0]                 tx_data;
   logic                        tx_valid;
   logic                        tx_ready;
   logic [63:0]                 rx_data;
   logic                        rx_valid;
   qeci_link_pkg::link_status_e status;
   qeci_link_pkg::link_ecode_e  ecode;

   test_cfg_if cfg ();

   link_reset_seq #(
      .RESET_CYCLES(RESET_CYCLES)
   ) i_reset_seq (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .soft_reset(soft_reset),
      .link_rst_n(link_rst_n)
   );

   test_ctrl_regs i_regs (
      .FCLK      (FCLK),
      .ARSTn     (ARSTn),
      .reg_req   (reg_req),
      .reg_we    (reg_we),
      .reg_addr  (reg_addr),
      .reg_wdata (reg_wdata),
      .reg_ack   (reg_ack),
      .reg_rdata (reg_rdata),
      .cfg       (cfg.regs),
      .status    (status),
      .ecode     (ecode),
      .soft_reset(soft_reset)
   );

   pattern_gen i_gen (
      .FCLK      (FCLK),
      .link_rst_n(link_rst_n),
      .cfg       (cfg.gen),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready)
   );

   lane_model #(
      .ALIGN_WORDS (ALIGN_WORDS),
      .LANE_LATENCY(LANE_LATENCY)
   ) i_lane (
      .FCLK      (FCLK),
      .link_rst_n(link_rst_n),
      .cfg       (cfg.lane),
      .tx_data   (tx_data),
      .tx_valid  (tx_valid),
      .tx_ready  (tx_ready),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid),
      .status    (status),
      .ecode     (ecode)
   );

   pattern_check i_check (
      .FCLK      (FCLK),
      .link_rst_n(link_rst_n),
      .cfg       (cfg.chk),
      .rx_data   (rx_data),
      .rx_valid  (rx_valid)
   );

   // Board LEDs
   assign led[0] = (status == qeci_link_pkg::LINK_UP);
   assign led[1] = (ecode == qeci_link_pkg::NONE);

endmodule

/* logic/test_ctrl_regs.sv */
/* Host register block on a four-phase req/ack port.
   Reset by ARSTn only, so configuration survives a soft reset.
   CONTROL bits 1 to 3 are one-cycle pulses and read back as 0. */

module test_ctrl_regs (
   input  logic                       FCLK,
   input  logic                       ARSTn,
   input  logic                       reg_req,
   input  logic                       reg_we,
   input  logic [2:0]                 reg_addr,
   input  logic [31:0]                reg_wdata,
   output logic                       reg_ack,
   output logic [31:0]                reg_rdata,
   test_cfg_if.regs                   cfg,
   input  qeci_link_pkg::link_status_e status,
   input  qeci_link_pkg::link_ecode_e  ecode,
   output logic                       soft_reset
);

   logic        access;
   logic [31:0] rd_mux;

   // One access per handshake, on the cycle before ack rises
   assign access = reg_req && !reg_ack;

   always_comb begin
      case (qeci_link_pkg::reg_addr_e'(reg_addr))
         qeci_link_pkg::CONTROL:   rd_mux = {31'd0, cfg.gen_enable};
         qeci_link_pkg::START_LO:  rd_mux = cfg.start_value[31:0];
         qeci_link_pkg::START_HI:  rd_mux = cfg.start_value[63:32];
         qeci_link_pkg::LINK_STAT: rd_mux = {23'd0, cfg.error_flag, ecode, status};
         qeci_link_pkg::ERR_COUNT: rd_mux = cfg.error_count;
         qeci_link_pkg::WORDS_LO:  rd_mux = cfg.words_checked;
         default:                  rd_mux = 32'd0;
      endcase
   end

   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         reg_ack           <= 1'b0;
         reg_rdata         <= '0;
         cfg.gen_enable    <= 1'b0;
         cfg.start_value   <= '0;
         cfg.inject_data   <= 1'b0;
         cfg.inject_header <= 1'b0;
         soft_reset        <= 1'b0;
      end else begin
         // Ack tracks req with one cycle of delay in both directions
         reg_ack           <= reg_req;
         cfg.inject_data   <= 1'b0;
         cfg.inject_header <= 1'b0;
         soft_reset        <= 1'b0;
         if (access && reg_we) begin
            case (qeci_link_pkg::reg_addr_e'(reg_addr))
               qeci_link_pkg::CONTROL: begin
                  cfg.gen_enable    <= reg_wdata[0];
                  soft_reset        <= reg_wdata[1];
                  cfg.inject_data   <= reg_wdata[2];
                  cfg.inject_header <= reg_wdata[3];
               end
               qeci_link_pkg::START_LO: begin
                  cfg.start_value[31:0] <= reg_wdata;
               end
               qeci_link_pkg::START_HI: begin
                  cfg.start_value[63:32] <= reg_wdata;
               end
               // Status and counters are read-only
               default: begin
                  cfg.gen_enable <= cfg.gen_enable;
               end
            endcase
         end else if (access) begin
            reg_rdata <= rd_mux;
         end
      end
   end

endmodule

/* logic/lane_model.sv */
/* Behavioral stand-in for the transceiver lane: sync-header framing,
   ALIGN training and a fixed LANE_LATENCY delay (1 or more), all on FCLK.
   Injected faults apply to the next transferred data word. */

module lane_model #(
   parameter int ALIGN_WORDS  = 8,
   parameter int LANE_LATENCY = 4
) (
   input  logic                       FCLK,
   input  logic                       link_rst_n,
   test_cfg_if.lane                   cfg,
   input  logic [63:0]                tx_data,
   input  logic                       tx_valid,
   output logic                       tx_ready,
   output logic [63:0]                rx_data,
   output logic                       rx_valid,
   output qeci_link_pkg::link_status_e status,
   output qeci_link_pkg::link_ecode_e  ecode
);

   localparam int ACW = $clog2(ALIGN_WORDS + 1);

   qeci_link_pkg::lane_word_t tx_word;
   qeci_link_pkg::lane_word_t pipe [LANE_LATENCY];
   qeci_link_pkg::lane_word_t rx_word;
   logic [LANE_LATENCY-1:0]   live;
   logic                      rx_live;
   logic                      tx_xfer;
   logic                      hdr_pend;
   logic                      data_pend;
   logic                      hdr_fault;
   logic                      data_fault;
   logic                      rx_align;
   logic                      rx_bad_hdr;
   logic [ACW-1:0]            align_cnt;

   assign tx_ready   = (status == qeci_link_pkg::LINK_UP);
   assign tx_xfer    = tx_valid && tx_ready;
   assign hdr_fault  = hdr_pend || cfg.inject_header;
   assign data_fault = data_pend || cfg.inject_data;

   // A pulse arms the fault until the next data word goes out
   always_ff @(posedge FCLK or negedge link_rst_n) begin
      if (!link_rst_n) begin
         hdr_pend  <= 1'b0;
         data_pend <= 1'b0;
      end else begin
         hdr_pend  <= hdr_fault && !tx_xfer;
         data_pend <= data_fault && !tx_xfer;
      end
   end

   // Framing sends ALIGN until link up and then data or IDLE
   always_comb begin
      tx_word.hdr                    = qeci_link_pkg::CTRL_HDR;
      tx_word.payload.ctrl.ctrl_type = tx_ready ? qeci_link_pkg::CTRL_IDLE
                                                : qeci_link_pkg::CTRL_ALIGN;
      tx_word.payload.ctrl.reserved  = '0;
      if (tx_xfer) begin
         // Header 11 is never a legal sync header
         tx_word.hdr          = hdr_fault ? 2'b11 : qeci_link_pkg::DATA_HDR;
         tx_word.payload.data = {tx_data[63:1], tx_data[0] ^ data_fault};
      end
   end

   // Lane delay line
   always_ff @(posedge FCLK) begin
      pipe[0] <= tx_word;
      for (int i = 1; i < LANE_LATENCY; i++) begin
         pipe[i] <= pipe[i-1];
      end
   end

   // Marks which stages hold words sent since reset release
   always_ff @(posedge FCLK or negedge link_rst_n) begin
      if (!link_rst_n) begin
         live <= '0;
      end else begin
         live <= LANE_LATENCY'({live, 1'b1});
      end
   end

   assign rx_word = pipe[LANE_LATENCY-1];
   assign rx_live = live[LANE_LATENCY-1];

   // Receiver reads the payload as data or control by its header
   assign rx_align   = (rx_word.hdr == qeci_link_pkg::CTRL_HDR) &&
                       (rx_word.payload.ctrl.ctrl_type == qeci_link_pkg::CTRL_ALIGN);
   assign rx_bad_hdr = (rx_word.hdr != qeci_link_pkg::DATA_HDR) &&
                       (rx_word.hdr != qeci_link_pkg::CTRL_HDR);
   assign rx_valid   = rx_live && tx_ready && (rx_word.hdr == qeci_link_pkg::DATA_HDR);
   assign rx_data    = rx_word.payload.data;

   // Training and error code
   always_ff @(posedge FCLK or negedge link_rst_n) begin
      if (!link_rst_n) begin
         status    <= qeci_link_pkg::RESET;
         ecode     <= qeci_link_pkg::NONE;
         align_cnt <= '0;
      end else begin
         case (status)
            qeci_link_pkg::RESET: begin
               status <= qeci_link_pkg::TRAINING;
            end
            qeci_link_pkg::TRAINING: begin
               if (rx_live) begin
                  if (rx_align) begin
                     // ALIGN_WORDS in a row brings the link up
                     if (align_cnt == ACW'(ALIGN_WORDS - 1)) begin
                        status <= qeci_link_pkg::LINK_UP;
                     end
                     align_cnt <= align_cnt + 1'b1;
                  end else begin
                     align_cnt <= '0;
                  end
               end
            end
            default: begin
               status <= status;
            end
         endcase
         // Sticky until the next link reset
         if (rx_live && rx_bad_hdr) begin
            ecode <= qeci_link_pkg::HEADER;
         end
      end
   end

endmodule

/* logic/pattern_check.sv */
/* Receive-side checker. The reference never resyncs, so one lost word
   makes every later word a mismatch. */

module pattern_check (
   input  logic        FCLK,
   input  logic        link_rst_n,
   test_cfg_if.chk     cfg,
   input  logic [63:0] rx_data,
   input  logic        rx_valid
);

   logic [63:0] ref_q;
   logic        mismatch;

   assign mismatch = rx_valid && (rx_data != ref_q);

   // Reference count loaded with the same start value as the generator
   always_ff @(posedge FCLK) begin
      if (!link_rst_n) begin
         ref_q <= cfg.start_value;
      end else if (rx_valid) begin
         ref_q <= ref_q + 64'd1;
      end
   end

   // Results update one cycle after the word
   always_ff @(posedge FCLK or negedge link_rst_n) begin
      if (!link_rst_n) begin
         cfg.error_count   <= '0;
         cfg.words_checked <= '0;
         cfg.error_flag    <= 1'b0;
      end else begin
         if (rx_valid) begin
            cfg.words_checked <= cfg.words_checked + 32'd1;
         end
         if (mismatch) begin
            cfg.error_count <= cfg.error_count + 32'd1;
            cfg.error_flag  <= 1'b1;
         end
      end
   end

endmodule

/* logic/pattern_gen.sv */
/* Incrementing 64-bit pattern source with valid/ready.
   The start value is loaded while the link is in reset. */

module pattern_gen (
   input  logic        FCLK,
   input  logic        link_rst_n,
   test_cfg_if.gen     cfg,
   output logic [63:0] tx_data,
   output logic        tx_valid,
   input  logic        tx_ready
);

   logic        tx_xfer;
   logic [63:0] word_q;

   assign tx_xfer = tx_valid && tx_ready;
   assign tx_data = word_q;

   // Valid follows the enable; it only drops when the enable does
   always_ff @(posedge FCLK or negedge link_rst_n) begin
      if (!link_rst_n) begin
         tx_valid <= 1'b0;
      end else begin
         tx_valid <= cfg.gen_enable;
      end
   end

   // Word holds under back-pressure and steps on each transfer
   always_ff @(posedge FCLK) begin
      if (!link_rst_n) begin
         word_q <= cfg.start_value;
      end else if (tx_xfer) begin
         word_q <= word_q + 64'd1;
      end
   end

endmodule

/* logic/link_reset_seq.sv */
/* Counted link reset, released synchronously to FCLK.
   RESET_CYCLES must be 2 or more. A soft reset takes effect one edge after its pulse. */

module link_reset_seq #(
   parameter int RESET_CYCLES = 16
) (
   input  logic FCLK,
   input  logic ARSTn,
   input  logic soft_reset,
   output logic link_rst_n
);

   localparam int CW = $clog2(RESET_CYCLES);

   logic [1:0]    sync_q;
   logic [CW-1:0] hold_cnt;

   // Two-flop synchronizer on the combined request
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         sync_q <= 2'b00;
      end else if (soft_reset) begin
         sync_q <= 2'b00;
      end else begin
         sync_q <= {sync_q[0], 1'b1};
      end
   end

   // Hold the link in reset for RESET_CYCLES after the request clears
   always_ff @(posedge FCLK or negedge ARSTn) begin
      if (!ARSTn) begin
         hold_cnt   <= '0;
         link_rst_n <= 1'b0;
      end else if (!sync_q[1]) begin
         hold_cnt   <= '0;
         link_rst_n <= 1'b0;
      end else if (hold_cnt == CW'(RESET_CYCLES - 1)) begin
         link_rst_n <= 1'b1;
      end else begin
         hold_cnt <= hold_cnt + 1'b1;
      end
   end

endmodule

/* logic/test_cfg_if.sv */
/* Configuration and result bundle between the register block,
   the pattern generator, the checker and the lane model. */

interface test_cfg_if;

   logic        gen_enable;
   logic [63:0] start_value;
   logic        inject_data;
   logic        inject_header;
   logic [31:0] error_count;
   logic [31:0] words_checked;
   logic        error_flag;

   modport regs (
      output gen_enable, start_value, inject_data, inject_header,
      input  error_count, words_checked, error_flag
   );

   modport gen (
      input gen_enable, start_value
   );

   modport chk (
      input  start_value,
      output error_count, words_checked, error_flag
   );

   // Fault pulses, one cycle each
   modport lane (
      input inject_data, inject_header
   );

endinterface

/* logic/qeci_link_pkg.sv */
/* Shared types for the link self-test harness.
   The lane header field is plain 2-bit so that invalid values can be carried. */

package qeci_link_pkg;

   // Link state as reported by the PHY
   typedef enum logic [3:0] {
      RESET    = 4'd0,
      TRAINING = 4'd2,
      LINK_UP  = 4'd4
   } link_status_e;

   typedef enum logic [3:0] {
      NONE   = 4'd0,
      HEADER = 4'd1
   } link_ecode_e;

   // 00 and 11 are invalid on the line
   typedef enum logic [1:0] {
      DATA_HDR = 2'b01,
      CTRL_HDR = 2'b10
   } sync_hdr_e;

   typedef struct packed {
      logic [7:0]  ctrl_type;
      logic [55:0] reserved;
   } ctrl_word_t;

   localparam logic [7:0] CTRL_ALIGN = 8'h78;
   localparam logic [7:0] CTRL_IDLE  = 8'h1e;

   // Same 64 bits, read as data or as control depending on the header
   typedef union packed {
      logic [63:0] data;
      ctrl_word_t  ctrl;
   } lane_payload_u;

   typedef struct packed {
      logic [1:0]    hdr;
      lane_payload_u payload;
   } lane_word_t;

   // Host register map
   typedef enum logic [2:0] {
      CONTROL   = 3'd0,
      START_LO  = 3'd1,
      START_HI  = 3'd2,
      LINK_STAT = 3'd3,
      ERR_COUNT = 3'd4,
      WORDS_LO  = 3'd5
   } reg_addr_e;

endpackage
